// ==== logic/spmm_cfg_pkg.sv ====
`default_nettype none

package spmm_cfg_pkg;

  // Datapath widths
  localparam int DATA_WIDTH    = 8;
  localparam int WH_DATA_WIDTH = 12;

  // H is binary, so a stored entry is only its column index
  localparam int COL_IDX_WIDTH  = 6;
  localparam int ROW_LEN_WIDTH  = 7;
  localparam int NUM_NODE_WIDTH = 5;
  localparam int ROW_IDX_WIDTH  = 5;

  // Default sizes, overridden from the top level
  localparam int DEF_NUM_FEATURE_OUT = 4;
  localparam int DEF_H_DEPTH         = 256;
  localparam int DEF_NODE_DEPTH      = 32;

endpackage

`default_nettype wire

// ==== logic/spmm_types_pkg.sv ====
`default_nettype none

package spmm_types_pkg;

  // One stored nonzero of H
  typedef struct packed {
    logic [spmm_cfg_pkg::COL_IDX_WIDTH-1:0] col_idx;
  } h_entry_t;

  // Per-row descriptor in the node memory
  typedef struct packed {
    logic [spmm_cfg_pkg::ROW_LEN_WIDTH-1:0]  row_len;
    logic [spmm_cfg_pkg::NUM_NODE_WIDTH-1:0] num_node;
    logic                                    src_flag;
  } node_info_t;

  // Rides along with a row until it leaves the collector
  typedef struct packed {
    logic [spmm_cfg_pkg::ROW_IDX_WIDTH-1:0]  row_idx;
    logic [spmm_cfg_pkg::NUM_NODE_WIDTH-1:0] num_node;
    logic                                    src_flag;
  } row_tag_t;

  typedef enum logic [1:0] {
    H_MEM,
    NODE_MEM,
    WGT_MEM
  } load_target_e;

  // Data is wide enough for a node_info_t, the widest word loaded
  typedef struct packed {
    logic                                           valid;
    load_target_e                                   target;
    logic [$clog2(spmm_cfg_pkg::DEF_H_DEPTH)-1:0]   addr;
    logic [3:0]                                     fsel;  // up to 16 PEs
    logic [$bits(node_info_t)-1:0]                  data;
  } load_req_t;

endpackage

`default_nettype wire

// ==== logic/sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  T                         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output T                         rdata_o
);

  T mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read data appears one cycle after the address
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

// ==== logic/spmm_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_controller #(
  parameter int H_DEPTH    = 256,
  parameter int NODE_DEPTH = 32
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start_i,
  input  logic [spmm_cfg_pkg::ROW_IDX_WIDTH:0]      num_rows_i,
  input  logic [spmm_cfg_pkg::ROW_IDX_WIDTH:0]      rows_out_i,
  output logic [$clog2(NODE_DEPTH)-1:0]             node_addr_o,
  input  spmm_types_pkg::node_info_t                node_info_i,
  output logic [$clog2(H_DEPTH)-1:0]                h_addr_o,
  output logic                                      spmm_vld_o,
  output logic                                      pe_vld_o,
  output spmm_types_pkg::node_info_t                node_info_o,
  output spmm_types_pkg::row_tag_t                  tag_o,
  output logic                                      busy_o,
  output logic                                      done_o
);

  localparam int RIW     = spmm_cfg_pkg::ROW_IDX_WIDTH;
  localparam int RLW     = spmm_cfg_pkg::ROW_LEN_WIDTH;
  localparam int NODE_AW = $clog2(NODE_DEPTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_STREAM
  } state_e;

  state_e                  state_q;
  logic [RIW-1:0]          row_idx_q;
  logic [RIW:0]            num_rows_q;
  logic [RIW:0]            base_q;
  logic [$clog2(H_DEPTH)-1:0] h_ptr_q;
  logic [RLW-1:0]          entry_cnt_q;
  logic                    run_q;
  logic                    last_entry;
  logic                    last_row;

  assign node_addr_o = NODE_AW'(row_idx_q);
  assign h_addr_o    = h_ptr_q;
  assign busy_o      = (state_q != ST_IDLE);

  assign last_entry = (entry_cnt_q == node_info_i.row_len - RLW'(1));
  assign last_row   = (({1'b0, row_idx_q} + 1'b1) == num_rows_q);

  // Collector counter is free running, so compare against its value at start
  assign done_o = run_q && ((rows_out_i - base_q) == num_rows_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      row_idx_q   <= '0;
      num_rows_q  <= '0;
      base_q      <= '0;
      h_ptr_q     <= '0;
      entry_cnt_q <= '0;
      run_q       <= 1'b0;
      spmm_vld_o  <= 1'b0;
      pe_vld_o    <= 1'b0;
    end else begin
      // Strobes are registered to line up with the H read data
      spmm_vld_o <= (state_q == ST_STREAM);
      pe_vld_o   <= (state_q == ST_STREAM) && (entry_cnt_q == '0);
      if (done_o) begin
        run_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            num_rows_q  <= num_rows_i;
            base_q      <= rows_out_i;
            row_idx_q   <= '0;
            h_ptr_q     <= '0;
            entry_cnt_q <= '0;
            run_q       <= 1'b1;
            state_q     <= ST_FETCH;
          end
        end
        // Node info read in flight, also the bubble between rows
        ST_FETCH: begin
          state_q <= ST_STREAM;
        end
        ST_STREAM: begin
          h_ptr_q <= h_ptr_q + 1'b1;
          if (last_entry) begin
            entry_cnt_q <= '0;
            row_idx_q   <= row_idx_q + 1'b1;
            state_q     <= last_row ? ST_IDLE : ST_FETCH;
          end else begin
            entry_cnt_q <= entry_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Row descriptor and tag follow the entries
  always_ff @(posedge clk) begin
    if (state_q == ST_STREAM) begin
      node_info_o      <= node_info_i;
      tag_o.row_idx    <= row_idx_q;
      tag_o.num_node   <= node_info_i.num_node;
      tag_o.src_flag   <= node_info_i.src_flag;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sparse_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparse_pe (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             spmm_vld_i,
  input  logic                                             pe_vld_i,
  input  spmm_types_pkg::h_entry_t                         entry_i,
  input  spmm_types_pkg::node_info_t                       node_info_i,
  input  spmm_types_pkg::row_tag_t                         tag_i,
  output logic [spmm_cfg_pkg::COL_IDX_WIDTH-1:0]           wgt_addr_o,
  input  logic signed [spmm_cfg_pkg::DATA_WIDTH-1:0]       wgt_dout_i,
  output logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0]    sum_o,
  output spmm_types_pkg::row_tag_t                         tag_o,
  output logic                                             row_done_o
);

  localparam int DW  = spmm_cfg_pkg::DATA_WIDTH;
  localparam int WHW = spmm_cfg_pkg::WH_DATA_WIDTH;
  localparam int RLW = spmm_cfg_pkg::ROW_LEN_WIDTH;

  logic [spmm_cfg_pkg::COL_IDX_WIDTH-1:0] col_idx_q;
  logic                     vld_q1;
  logic                     vld_q2;
  logic                     first_q1;
  logic                     first_q2;
  logic [RLW-1:0]           row_len_q1;
  logic [RLW-1:0]           row_len_q2;
  logic [RLW-1:0]           cnt_q;
  logic [RLW-1:0]           cnt_next;
  logic                     done_q;
  logic signed [WHW-1:0]    wgt_ext;
  logic signed [WHW-1:0]    sum_q;
  spmm_types_pkg::row_tag_t tag_q;
  spmm_types_pkg::row_tag_t tag_d1;
  spmm_types_pkg::row_tag_t tag_d2;

  assign wgt_addr_o = col_idx_q;
  assign sum_o      = sum_q;
  assign tag_o      = tag_d2;

  // H entries are all ones, so the weight word is the product
  assign wgt_ext  = {{(WHW - DW){wgt_dout_i[DW-1]}}, wgt_dout_i};
  assign cnt_next = first_q2 ? RLW'(1) : cnt_q + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q1     <= 1'b0;
      vld_q2     <= 1'b0;
      first_q1   <= 1'b0;
      first_q2   <= 1'b0;
      cnt_q      <= '0;
      done_q     <= 1'b0;
      row_done_o <= 1'b0;
    end else begin
      vld_q1     <= spmm_vld_i;
      vld_q2     <= vld_q1;
      first_q1   <= pe_vld_i;
      first_q2   <= first_q1;
      if (vld_q2) begin
        cnt_q <= cnt_next;
      end
      done_q     <= vld_q2 && (cnt_next == row_len_q2);
      // Extra stage gives the fixed four cycle row latency
      row_done_o <= done_q;
    end
  end

  // Address and row length, two stages to meet the weight read
  always_ff @(posedge clk) begin
    col_idx_q  <= entry_i.col_idx;
    row_len_q1 <= node_info_i.row_len;
    row_len_q2 <= row_len_q1;
  end

  // Accumulate, wrapping at 12 bits
  always_ff @(posedge clk) begin
    if (vld_q2) begin
      sum_q <= first_q2 ? wgt_ext : sum_q + wgt_ext;
    end
  end

  // Tag stays until the next row starts, then the delay lines it up
  always_ff @(posedge clk) begin
    if (pe_vld_i) begin
      tag_q <= tag_i;
    end
    tag_d1 <= tag_q;
    tag_d2 <= tag_d1;
  end

endmodule

`default_nettype wire

// ==== logic/wh_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_collector #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          row_done_i,
  input  logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0] sums_i [NUM_FEATURE_OUT],
  input  spmm_types_pkg::row_tag_t                      tag_i,
  output logic                                          wh_vld_o,
  output logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0] wh_sum_o [NUM_FEATURE_OUT],
  output spmm_types_pkg::row_tag_t                      wh_tag_o,
  output logic [spmm_cfg_pkg::ROW_IDX_WIDTH:0]          rows_out_o
);

  // Output strobe and emitted row count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o   <= 1'b0;
      rows_out_o <= '0;
    end else begin
      wh_vld_o <= row_done_i;
      if (row_done_i) begin
        rows_out_o <= rows_out_o + 1'b1;
      end
    end
  end

  // Row payload, held until the next row finishes
  always_ff @(posedge clk) begin
    if (row_done_i) begin
      wh_sum_o <= sums_i;
      wh_tag_o <= tag_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spmm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_top #(
  parameter int NUM_FEATURE_OUT = spmm_cfg_pkg::DEF_NUM_FEATURE_OUT,
  parameter int H_DEPTH         = spmm_cfg_pkg::DEF_H_DEPTH,
  parameter int NODE_DEPTH      = spmm_cfg_pkg::DEF_NODE_DEPTH
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  spmm_types_pkg::load_req_t                     load_req_i,
  input  logic                                          start_i,
  input  logic [spmm_cfg_pkg::ROW_IDX_WIDTH:0]          num_rows_i,
  output logic                                          busy_o,
  output logic                                          done_o,
  output logic                                          wh_vld_o,
  output logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0] wh_sum_o [NUM_FEATURE_OUT],
  output spmm_types_pkg::row_tag_t                      wh_tag_o
);

  localparam int DW      = spmm_cfg_pkg::DATA_WIDTH;
  localparam int CIW     = spmm_cfg_pkg::COL_IDX_WIDTH;
  localparam int H_AW    = $clog2(H_DEPTH);
  localparam int NODE_AW = $clog2(NODE_DEPTH);
  localparam int W_DEPTH = 2 ** CIW;

  logic                         h_we;
  logic                         node_we;
  logic [H_AW-1:0]              h_addr;
  logic [NODE_AW-1:0]           node_addr;
  spmm_types_pkg::h_entry_t     h_entry;
  spmm_types_pkg::node_info_t   node_rd;
  spmm_types_pkg::node_info_t   pe_info;
  spmm_types_pkg::row_tag_t     ctrl_tag;
  logic                         spmm_vld;
  logic                         pe_vld;
  logic [spmm_cfg_pkg::ROW_IDX_WIDTH:0] rows_out;
  logic [NUM_FEATURE_OUT-1:0]   pe_row_done;
  logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0] pe_sum [NUM_FEATURE_OUT];
  spmm_types_pkg::row_tag_t     pe_tag [NUM_FEATURE_OUT];

  // Load decode
  assign h_we    = load_req_i.valid && (load_req_i.target == spmm_types_pkg::H_MEM);
  assign node_we = load_req_i.valid && (load_req_i.target == spmm_types_pkg::NODE_MEM);

  sync_ram #(.T(spmm_types_pkg::h_entry_t), .DEPTH(H_DEPTH)) u_h_ram (
    .clk     (clk),
    .we_i    (h_we),
    .waddr_i (H_AW'(load_req_i.addr)),
    .wdata_i (spmm_types_pkg::h_entry_t'(load_req_i.data[CIW-1:0])),
    .raddr_i (h_addr),
    .rdata_o (h_entry)
  );

  sync_ram #(.T(spmm_types_pkg::node_info_t), .DEPTH(NODE_DEPTH)) u_node_ram (
    .clk     (clk),
    .we_i    (node_we),
    .waddr_i (NODE_AW'(load_req_i.addr)),
    .wdata_i (spmm_types_pkg::node_info_t'(load_req_i.data)),
    .raddr_i (node_addr),
    .rdata_o (node_rd)
  );

  spmm_controller #(.H_DEPTH(H_DEPTH), .NODE_DEPTH(NODE_DEPTH)) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_rows_i  (num_rows_i),
    .rows_out_i  (rows_out),
    .node_addr_o (node_addr),
    .node_info_i (node_rd),
    .h_addr_o    (h_addr),
    .spmm_vld_o  (spmm_vld),
    .pe_vld_o    (pe_vld),
    .node_info_o (pe_info),
    .tag_o       (ctrl_tag),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // One weight column and one PE per output feature
  for (genvar f = 0; f < NUM_FEATURE_OUT; f++) begin : g_pe
    logic                 wgt_we;
    logic [CIW-1:0]       wgt_addr;
    logic signed [DW-1:0] wgt_dout;

    assign wgt_we = load_req_i.valid && (load_req_i.target == spmm_types_pkg::WGT_MEM)
                    && (int'(load_req_i.fsel) == f);

    sync_ram #(.T(logic signed [DW-1:0]), .DEPTH(W_DEPTH)) u_wgt_ram (
      .clk     (clk),
      .we_i    (wgt_we),
      .waddr_i (CIW'(load_req_i.addr)),
      .wdata_i (load_req_i.data[DW-1:0]),
      .raddr_i (wgt_addr),
      .rdata_o (wgt_dout)
    );

    sparse_pe u_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .spmm_vld_i  (spmm_vld),
      .pe_vld_i    (pe_vld),
      .entry_i     (h_entry),
      .node_info_i (pe_info),
      .tag_i       (ctrl_tag),
      .wgt_addr_o  (wgt_addr),
      .wgt_dout_i  (wgt_dout),
      .sum_o       (pe_sum[f]),
      .tag_o       (pe_tag[f]),
      .row_done_o  (pe_row_done[f])
    );
  end

  // PEs run in lockstep; the tag comes from PE 0
  wh_collector #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_collector (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_done_i (&pe_row_done),
    .sums_i     (pe_sum),
    .tag_i      (pe_tag[0]),
    .wh_vld_o   (wh_vld_o),
    .wh_sum_o   (wh_sum_o),
    .wh_tag_o   (wh_tag_o),
    .rows_out_o (rows_out)
  );

endmodule

`default_nettype wire

// ==== verification/spmm_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_sva (
  input logic clk,
  input logic rst_n,
  input logic start_i,
  input logic spmm_vld_i,
  input logic pe_vld_i,
  input logic busy_i,
  input logic done_i,
  input logic wh_vld_i
);

  int unsigned fail_cnt = 0;
  logic        in_run_q;

  // Open from an accepted start until done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_run_q <= 1'b0;
    end else if (start_i && !busy_i) begin
      in_run_q <= 1'b1;
    end else if (done_i) begin
      in_run_q <= 1'b0;
    end
  end

  a_pe_vld_with_spmm_vld: assert property (@(posedge clk) disable iff (!rst_n)
    pe_vld_i |-> spmm_vld_i)
    else begin
      $error("pe_vld asserted without spmm_vld");
      fail_cnt++;
    end

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else begin
      $error("done_o held for more than one cycle");
      fail_cnt++;
    end

  // Last row leaves in the same cycle as done
  a_done_with_row: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> wh_vld_i)
    else begin
      $error("done_o without a row on the output");
      fail_cnt++;
    end

  a_row_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    wh_vld_i |-> in_run_q)
    else begin
      $error("wh_vld_o outside a run");
      fail_cnt++;
    end

  a_idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !busy_i)
    else begin
      $error("busy_o high right after reset");
      fail_cnt++;
    end

endmodule

bind spmm_top spmm_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .start_i    (start_i),
  .spmm_vld_i (spmm_vld),
  .pe_vld_i   (pe_vld),
  .busy_i     (busy_o),
  .done_i     (done_o),
  .wh_vld_i   (wh_vld_o)
);

`default_nettype wire

// ==== verification/spmm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_tb;

  localparam int NF    = spmm_cfg_pkg::DEF_NUM_FEATURE_OUT;
  localparam int WHW   = spmm_cfg_pkg::WH_DATA_WIDTH;
  localparam int DW    = spmm_cfg_pkg::DATA_WIDTH;
  localparam int RIW   = spmm_cfg_pkg::ROW_IDX_WIDTH;
  localparam int NCOL  = 2 ** spmm_cfg_pkg::COL_IDX_WIDTH;
  localparam int AW    = $clog2(spmm_cfg_pkg::DEF_H_DEPTH);
  localparam int LDW   = $bits(spmm_types_pkg::node_info_t);
  localparam int NROWS = 9;
  localparam int NRUNS = 2;

  typedef struct packed {
    logic [1:0] run;
    logic [5:0] start;
    logic [5:0] stride;
    logic [6:0] len;
    logic [4:0] num_node;
    logic       src_flag;
  } row_spec_t;

  typedef struct packed {
    logic [NF-1:0][WHW-1:0]   sums;
    spmm_types_pkg::row_tag_t tag;
  } exp_row_t;

  // Row columns are start + k * stride modulo 64, odd strides keep them distinct
  // run, start, stride, len, num_node, src_flag
  localparam row_spec_t ROW_TABLE [NROWS] = '{
    '{2'd0, 6'd5,  6'd1, 7'd1,  5'd3,  1'b1},
    '{2'd0, 6'd12, 6'd7, 7'd3,  5'd9,  1'b0},
    '{2'd0, 6'd40, 6'd3, 7'd17, 5'd1,  1'b1},
    '{2'd0, 6'd63, 6'd1, 7'd1,  5'd31, 1'b0},
    '{2'd0, 6'd0,  6'd5, 7'd8,  5'd16, 1'b1},
    '{2'd1, 6'd0,  6'd1, 7'd48, 5'd4,  1'b0},
    '{2'd1, 6'd10, 6'd1, 7'd1,  5'd7,  1'b1},
    '{2'd1, 6'd2,  6'd1, 7'd45, 5'd2,  1'b1},
    '{2'd1, 6'd50, 6'd9, 7'd5,  5'd20, 1'b0}
  };

  logic                      clk;
  logic                      rst_n;
  logic                      start_i;
  logic [RIW:0]              num_rows_i;
  spmm_types_pkg::load_req_t load_req;
  logic                      busy;
  logic                      done;
  logic                      wh_vld;
  logic signed [WHW-1:0]     wh_sum [NF];
  spmm_types_pkg::row_tag_t  wh_tag;

  logic signed [DW-1:0] wgt [NCOL][NF];
  exp_row_t             exp_q [$];
  int                   sum_err = 0;
  int                   tag_err = 0;
  int                   other_err = 0;
  int                   done_cnt = 0;

  spmm_top #(
    .NUM_FEATURE_OUT (NF),
    .H_DEPTH         (spmm_cfg_pkg::DEF_H_DEPTH),
    .NODE_DEPTH      (spmm_cfg_pkg::DEF_NODE_DEPTH)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_req_i (load_req),
    .start_i    (start_i),
    .num_rows_i (num_rows_i),
    .busy_o     (busy),
    .done_o     (done),
    .wh_vld_o   (wh_vld),
    .wh_sum_o   (wh_sum),
    .wh_tag_o   (wh_tag)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_sum(int feature, logic signed [WHW-1:0] got,
                           logic signed [WHW-1:0] exp);
    if (got !== exp) begin
      sum_err++;
      $display("error at %0t: feature %0d sum is %0d, expected %0d", $time, feature, got, exp);
    end
  endtask

  task automatic check_tag(spmm_types_pkg::row_tag_t got, spmm_types_pkg::row_tag_t exp);
    if (got !== exp) begin
      tag_err++;
      $display("error at %0t: tag row %0d nodes %0d src %0b, expected row %0d nodes %0d src %0b",
               $time, got.row_idx, got.num_node, got.src_flag,
               exp.row_idx, exp.num_node, exp.src_flag);
    end
  endtask

  task automatic load_word(spmm_types_pkg::load_target_e target, int addr, int fsel,
                           logic [LDW-1:0] data);
    @(posedge clk);
    #2;
    load_req.valid  = 1'b1;
    load_req.target = target;
    load_req.addr   = AW'(addr);
    load_req.fsel   = 4'(fsel);
    load_req.data   = data;
  endtask

  task automatic finish_loading();
    @(posedge clk);
    #2;
    load_req = '0;
  endtask

  // Second run pins columns 0 to 47 at -128 to force wrap
  task automatic load_weights(int run);
    logic signed [DW-1:0] w;
    for (int c = 0; c < NCOL; c++) begin
      for (int f = 0; f < NF; f++) begin
        if (run == 1 && c < 48) begin
          w = 8'h80;
        end else begin
          w = DW'($urandom);
        end
        wgt[c][f] = w;
        load_word(spmm_types_pkg::WGT_MEM, c, f, LDW'(w));
      end
    end
  endtask

  // Loads H and node info for one run, and predicts its rows
  task automatic load_run(int run, output int nrows);
    int                         hptr;
    int                         col;
    int                         sum [NF];
    spmm_types_pkg::node_info_t info;
    exp_row_t                   exp_row;
    hptr  = 0;
    nrows = 0;
    for (int r = 0; r < NROWS; r++) begin
      if (ROW_TABLE[r].run == run) begin
        for (int f = 0; f < NF; f++) begin
          sum[f] = 0;
        end
        for (int k = 0; k < ROW_TABLE[r].len; k++) begin
          col = (ROW_TABLE[r].start + k * ROW_TABLE[r].stride) % NCOL;
          load_word(spmm_types_pkg::H_MEM, hptr, 0, LDW'(col));
          hptr++;
          for (int f = 0; f < NF; f++) begin
            sum[f] += int'(wgt[col][f]);
          end
        end
        info.row_len  = ROW_TABLE[r].len;
        info.num_node = ROW_TABLE[r].num_node;
        info.src_flag = ROW_TABLE[r].src_flag;
        load_word(spmm_types_pkg::NODE_MEM, nrows, 0, info);
        // Keep 12 bits, sums wrap modulo 4096
        for (int f = 0; f < NF; f++) begin
          exp_row.sums[f] = sum[f][WHW-1:0];
        end
        exp_row.tag.row_idx  = RIW'(nrows);
        exp_row.tag.num_node = ROW_TABLE[r].num_node;
        exp_row.tag.src_flag = ROW_TABLE[r].src_flag;
        exp_q.push_back(exp_row);
        nrows++;
      end
    end
    finish_loading();
  endtask

  task automatic run_matrix(int run, int nrows);
    @(posedge clk);
    #2;
    start_i    = 1'b1;
    num_rows_i = (RIW + 1)'(nrows);
    @(posedge clk);
    #2;
    start_i = 1'b0;
    // A start while busy must be ignored
    if (run == 1) begin
      repeat (10) @(posedge clk);
      #2;
      if (!busy) begin
        other_err++;
        $display("busy_o was low in the middle of a run");
      end
      start_i    = 1'b1;
      num_rows_i = 3;
      @(posedge clk);
      #2;
      start_i = 1'b0;
    end
    while (done_cnt < run + 1) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    if (done_cnt != run + 1) begin
      other_err++;
      $display("done_o pulsed %0d times after %0d runs", done_cnt, run + 1);
    end
    if (exp_q.size() != 0) begin
      other_err++;
      $display("%0d expected rows never came out of run %0d", exp_q.size(), run);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    exp_row_t exp_row;
    if (rst_n) begin
      if (wh_vld) begin
        if (exp_q.size() == 0) begin
          other_err++;
          $display("A row came out that no test expected");
        end else begin
          exp_row = exp_q.pop_front();
          for (int f = 0; f < NF; f++) begin
            check_sum(f, wh_sum[f], exp_row.sums[f]);
          end
          check_tag(wh_tag, exp_row.tag);
        end
      end
      if (done) begin
        done_cnt++;
        if (busy) begin
          other_err++;
          $display("busy_o was still high when done_o pulsed");
        end
        if (exp_q.size() != 0) begin
          other_err++;
          $display("done_o pulsed with %0d rows still missing", exp_q.size());
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    limit = 2 * NF * NCOL + 50 * NRUNS + 50;
    for (int r = 0; r < NROWS; r++) begin
      limit += 2 * ROW_TABLE[r].len + 4;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout, the run did not finish within %0d clock cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    int nrows;
    void'($urandom(96));
    rst_n      = 1'b0;
    start_i    = 1'b0;
    num_rows_i = '0;
    load_req   = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int run = 0; run < NRUNS; run++) begin
      load_weights(run);
      load_run(run, nrows);
      run_matrix(run, nrows);
    end
    $display("sum errors: %0d, tag errors: %0d, other errors: %0d, assertion failures: %0d",
             sum_err, tag_err, other_err, UUT.u_sva.fail_cnt);
    if (sum_err + tag_err + other_err + int'(UUT.u_sva.fail_cnt) == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gat_spmm.f ====
logic/spmm_cfg_pkg.sv
logic/spmm_types_pkg.sv
logic/sync_ram.sv
logic/spmm_controller.sv
logic/sparse_pe.sv
logic/wh_collector.sv
logic/spmm_top.sv
verification/spmm_sva.sv
verification/spmm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SpMM testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f gat_spmm.f --top-module spmm_tb \
  -o spmm_sim || { echo "Build failed"; exit 1; }
./obj_dir/spmm_sim +verilator+error+limit+1000 > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
